//--- source/irq_defs_pkg.sv
package irq_defs_pkg;

   // request line numbering, lowest index wins arbitration
   localparam int irq_count = 3;                  // number of request lines
   localparam int irq_lclk  = 0;                  // line clock, top priority
   localparam int irq_rx    = 1;                  // console receiver
   localparam int irq_tx    = 2;                  // console transmitter

   typedef logic [15:0]          word_t;          // bus data word
   typedef logic [irq_count-1:0] irq_vec_t;       // one bit per request line

   localparam word_t vec_lclk = 16'o100;          // line clock vector
   localparam word_t vec_rx   = 16'o060;          // receiver vector
   localparam word_t vec_tx   = 16'o064;          // transmitter vector

   // next state of a device pending flop, fed with the next flag and enable
   function automatic logic pend_next
   (
      input logic pend,                           // current pending
      input logic flag_n,                         // flag after this edge
      input logic ie,                             // enable before this edge
      input logic ie_n,                           // enable after this edge
      input logic set_evt,                        // event that sets the flag
      input logic iack                            // acknowledge from the vic
   );
      logic keep;                                 // old request survives
      logic fire;                                 // new request edge
      keep = pend & ~iack;
      fire = set_evt | ~ie;                       // fresh event or enable rising
      return flag_n & ie_n & (keep | fire);       // flag or ie low drops it
   endfunction

endpackage

//--- source/dev_regs_pkg.sv
package dev_regs_pkg;

   typedef logic [2:0] reg_adr_t;                 // register select on the bus
   typedef logic [7:0] byte_t;                    // console character

   // register map of the subsystem
   localparam reg_adr_t adr_rcsr = 3'd0;          // receiver status
   localparam reg_adr_t adr_rbuf = 3'd1;          // receiver buffer
   localparam reg_adr_t adr_xcsr = 3'd2;          // transmitter status
   localparam reg_adr_t adr_xbuf = 3'd3;          // transmitter buffer
   localparam reg_adr_t adr_lks  = 3'd4;          // line clock status

   // status layout, same in every csr
   localparam int bit_flag = 7;                   // done, ready or monitor
   localparam int bit_ie   = 6;                   // interrupt enable

endpackage

//--- source/wbc_vic.sv
`timescale 1ns/1ps

module wbc_vic #(
   parameter int N = 1                                  // number of request lines
)
(
   input  logic                         wb_clk_i,       // system clock
   input  logic                         wb_rst_i,       // async reset
   output logic                         wb_irq_o,       // registered request to cpu
   output irq_defs_pkg::word_t          wb_dat_o,       // vector or unaddressed word
   input  logic                         wb_stb_i,       // vector read strobe
   input  logic                         wb_una_i,       // unaddressed read tag
   output logic                         wb_ack_o,       // vector read ack
   input  irq_defs_pkg::word_t          rsel,           // word for unaddressed reads
   input  irq_defs_pkg::word_t [N-1:0]  ivec,           // per line vectors
   input  logic [N-1:0]                 ireq,           // request lines
   output logic [N-1:0]                 iack            // acknowledge pulses
);

   // one code past the last line, all ones, marks no request
   typedef logic [$clog2(N+1)-1:0] sel_t;

   sel_t                nvec;                           // current winner, frozen in a cycle
   sel_t                nsel;                           // winner of the live requests
   irq_defs_pkg::word_t vsel;                           // vector of the winner
   logic                grant;                          // vector cycle accepted now

   always_comb
   begin
      nsel = '1;                                        // idle unless a line is up
      for (int i = N - 1; i >= 0; i--)
      begin
         if (ireq[i] && !iack[i])                       // line being acked is stale
         begin
            nsel = sel_t'(i);                           // lower index overrides
         end
      end
   end

   always_comb
   begin
      vsel = '0;                                        // no winner reads as zero
      for (int i = 0; i < N; i++)
      begin
         if (nvec == sel_t'(i))
         begin
            vsel = ivec[i];
         end
      end
   end

   assign grant = wb_stb_i & ~wb_ack_o & (wb_irq_o | wb_una_i); // first strobe cycle

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         wb_irq_o <= 1'b0;
         wb_ack_o <= 1'b0;
         iack     <= '0;
         nvec     <= '1;                                // nothing selected
      end
      else
      begin
         wb_ack_o <= grant;                             // one cycle after strobe
         wb_irq_o <= (nvec != '1) & ~(|iack);           // drop while a line is acked
         for (int i = 0; i < N; i++)
         begin
            iack[i] <= grant & ~wb_una_i & (nvec == sel_t'(i)); // single pulse
         end
         if (!wb_stb_i)
         begin
            nvec <= nsel;                               // arbitrate between cycles
         end
         else if (|iack)
         begin
            nvec <= '1;                                 // served, forget the winner
         end
      end
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (grant)
      begin
         wb_dat_o <= wb_una_i ? rsel : vsel;            // latched with the ack
      end
   end

endmodule

//--- source/line_clock.sv
`timescale 1ns/1ps

module line_clock
(
   input  logic                wb_clk_i,        // system clock
   input  logic                wb_rst_i,        // async reset
   input  logic                tick_i,          // external line tick
   input  logic                wr_i,            // csr write strobe
   input  irq_defs_pkg::word_t wdat_i,          // write data
   output irq_defs_pkg::word_t csr_o,           // status word
   output logic                ireq_o,          // request to the vic
   input  logic                iack_i           // acknowledge from the vic
);

   logic flag;                                  // monitor flag
   logic ie;                                    // interrupt enable
   logic pend;                                  // pending request
   logic flag_n;                                // next monitor flag
   logic ie_n;                                  // next enable
   logic clr;                                   // software clears the flag

   assign clr = wr_i & ~wdat_i[dev_regs_pkg::bit_flag];  // writing 0 clears

   always_comb
   begin
      flag_n = tick_i | (flag & ~clr);          // tick wins over a clear
      ie_n   = wr_i ? wdat_i[dev_regs_pkg::bit_ie] : ie;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         flag <= 1'b0;
         ie   <= 1'b0;
         pend <= 1'b0;
      end
      else
      begin
         flag <= flag_n;
         ie   <= ie_n;
         // every tick requests again, even with the flag still set
         pend <= irq_defs_pkg::pend_next(pend, flag_n, ie, ie_n, tick_i, iack_i);
      end
   end

   always_comb
   begin
      csr_o                         = '0;       // unused bits read 0
      csr_o[dev_regs_pkg::bit_flag] = flag;
      csr_o[dev_regs_pkg::bit_ie]   = ie;
   end

   assign ireq_o = pend;

endmodule

//--- source/console_port.sv
`timescale 1ns/1ps

module console_port
(
   input  logic                   wb_clk_i,     // system clock
   input  logic                   wb_rst_i,     // async reset
   input  logic                   wr_i,         // write strobe, ack cycle
   input  logic                   rd_i,         // read strobe, ack cycle
   input  dev_regs_pkg::reg_adr_t adr_i,        // register select
   input  irq_defs_pkg::word_t    wdat_i,       // write data
   output irq_defs_pkg::word_t    rdat_o,       // read data
   input  logic                   rx_stb_i,     // received character strobe
   input  dev_regs_pkg::byte_t    rx_dat_i,     // received character
   output logic                   tx_stb_o,     // character out strobe
   output dev_regs_pkg::byte_t    tx_dat_o,     // character out
   input  logic                   tx_done_i,    // transmitter finished
   output logic                   rx_ireq_o,    // receiver request
   output logic                   tx_ireq_o,    // transmitter request
   input  logic                   rx_iack_i,    // receiver acknowledge
   input  logic                   tx_iack_i     // transmitter acknowledge
);

   logic                rx_done;                // character waiting
   logic                rx_ie;
   logic                rx_pend;
   dev_regs_pkg::byte_t rx_buf;                 // last character in
   logic                tx_rdy;                 // transmitter free
   logic                tx_ie;
   logic                tx_pend;
   dev_regs_pkg::byte_t tx_buf;                 // last character out
   logic                rx_done_n;
   logic                rx_ie_n;
   logic                tx_rdy_n;
   logic                tx_ie_n;
   logic                rd_rbuf;                // buffer read clears done
   logic                wr_xbuf;                // buffer write starts output

   assign rd_rbuf = rd_i & (adr_i == dev_regs_pkg::adr_rbuf);
   assign wr_xbuf = wr_i & (adr_i == dev_regs_pkg::adr_xbuf);

   always_comb
   begin
      rx_done_n = rx_stb_i | (rx_done & ~rd_rbuf);    // new character beats the read
      tx_rdy_n  = tx_done_i | (tx_rdy & ~wr_xbuf);
      rx_ie_n   = rx_ie;
      tx_ie_n   = tx_ie;
      if (wr_i && adr_i == dev_regs_pkg::adr_rcsr)
      begin
         rx_ie_n = wdat_i[dev_regs_pkg::bit_ie];      // done is read only
      end
      if (wr_i && adr_i == dev_regs_pkg::adr_xcsr)
      begin
         tx_ie_n = wdat_i[dev_regs_pkg::bit_ie];      // ready is read only
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
      begin
         rx_done  <= 1'b0;
         rx_ie    <= 1'b0;
         rx_pend  <= 1'b0;
         tx_rdy   <= 1'b1;                            // idle transmitter is ready
         tx_ie    <= 1'b0;
         tx_pend  <= 1'b0;
         tx_stb_o <= 1'b0;
      end
      else
      begin
         rx_done  <= rx_done_n;
         rx_ie    <= rx_ie_n;
         tx_rdy   <= tx_rdy_n;
         tx_ie    <= tx_ie_n;
         tx_stb_o <= wr_xbuf;                         // one pulse per write
         rx_pend  <= irq_defs_pkg::pend_next(rx_pend, rx_done_n, rx_ie, rx_ie_n,
                                             rx_stb_i, rx_iack_i);
         tx_pend  <= irq_defs_pkg::pend_next(tx_pend, tx_rdy_n, tx_ie, tx_ie_n,
                                             tx_done_i, tx_iack_i);
      end
   end

   always_ff @(posedge wb_clk_i)
   begin
      if (rx_stb_i)
      begin
         rx_buf <= rx_dat_i;                          // overwrites an unread byte
      end
      if (wr_xbuf)
      begin
         tx_buf <= wdat_i[7:0];
      end
   end

   always_comb
   begin
      rdat_o = '0;
      case (adr_i)
         dev_regs_pkg::adr_rcsr:
         begin
            rdat_o[dev_regs_pkg::bit_flag] = rx_done;
            rdat_o[dev_regs_pkg::bit_ie]   = rx_ie;
         end
         dev_regs_pkg::adr_rbuf: rdat_o = irq_defs_pkg::word_t'(rx_buf);
         dev_regs_pkg::adr_xcsr:
         begin
            rdat_o[dev_regs_pkg::bit_flag] = tx_rdy;
            rdat_o[dev_regs_pkg::bit_ie]   = tx_ie;
         end
         dev_regs_pkg::adr_xbuf: rdat_o = irq_defs_pkg::word_t'(tx_buf);
         default:                rdat_o = '0;         // not a console register
      endcase
   end

   assign tx_dat_o  = tx_buf;
   assign rx_ireq_o = rx_pend;
   assign tx_ireq_o = tx_pend;

endmodule

//--- source/irq_subsys.sv
`timescale 1ns/1ps

module irq_subsys
(
   input  logic                   wb_clk_i,     // system clock
   input  logic                   wb_rst_i,     // async reset
   input  logic                   reg_stb_i,    // register strobe
   input  logic                   reg_we_i,     // register write
   input  dev_regs_pkg::reg_adr_t reg_adr_i,    // register address
   input  irq_defs_pkg::word_t    reg_dat_i,    // register write data
   output irq_defs_pkg::word_t    reg_dat_o,    // register read data
   output logic                   reg_ack_o,    // register ack
   input  logic                   iak_stb_i,    // vector read strobe
   input  logic                   iak_una_i,    // unaddressed tag
   input  irq_defs_pkg::word_t    rsel_i,       // unaddressed read word
   output irq_defs_pkg::word_t    iak_dat_o,    // vector read data
   output logic                   iak_ack_o,    // vector read ack
   output logic                   irq_o,        // request to cpu
   input  logic                   lclk_tick_i,  // line clock tick
   input  logic                   rx_stb_i,     // received character strobe
   input  dev_regs_pkg::byte_t    rx_dat_i,     // received character
   output logic                   tx_stb_o,     // character out strobe
   output dev_regs_pkg::byte_t    tx_dat_o,     // character out
   input  logic                   tx_done_i     // transmitter finished
);

   irq_defs_pkg::irq_vec_t                              ireq;     // device requests
   irq_defs_pkg::irq_vec_t                              iack;     // vic acknowledges
   irq_defs_pkg::word_t [irq_defs_pkg::irq_count-1:0]   ivec;     // vector table
   irq_defs_pkg::word_t                                 lks_dat;  // line clock csr
   irq_defs_pkg::word_t                                 con_dat;  // console read data
   logic                                                dev_wr;   // write on ack cycle
   logic                                                dev_rd;   // read on ack cycle
   logic                                                lks_sel;
   logic                                                con_sel;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i)
   begin
      if (wb_rst_i)
         reg_ack_o <= 1'b0;
      else
         reg_ack_o <= reg_stb_i & ~reg_ack_o;  // ack one cycle after strobe
   end

   assign dev_wr  = reg_ack_o & reg_we_i;
   assign dev_rd  = reg_ack_o & ~reg_we_i;
   assign lks_sel = (reg_adr_i == dev_regs_pkg::adr_lks);
   assign con_sel = reg_adr_i inside {dev_regs_pkg::adr_rcsr, dev_regs_pkg::adr_rbuf,
                                      dev_regs_pkg::adr_xcsr, dev_regs_pkg::adr_xbuf};

   // upper addresses read as zero
   assign reg_dat_o = lks_sel ? lks_dat : (con_sel ? con_dat : '0);

   assign ivec[irq_defs_pkg::irq_lclk] = irq_defs_pkg::vec_lclk;
   assign ivec[irq_defs_pkg::irq_rx]   = irq_defs_pkg::vec_rx;
   assign ivec[irq_defs_pkg::irq_tx]   = irq_defs_pkg::vec_tx;

   line_clock u_lclk
   (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .tick_i   (lclk_tick_i),
      .wr_i     (dev_wr & lks_sel),
      .wdat_i   (reg_dat_i),
      .csr_o    (lks_dat),
      .ireq_o   (ireq[irq_defs_pkg::irq_lclk]),
      .iack_i   (iack[irq_defs_pkg::irq_lclk])
   );

   console_port u_con
   (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .wr_i      (dev_wr & con_sel),
      .rd_i      (dev_rd & con_sel),
      .adr_i     (reg_adr_i),
      .wdat_i    (reg_dat_i),
      .rdat_o    (con_dat),
      .rx_stb_i  (rx_stb_i),
      .rx_dat_i  (rx_dat_i),
      .tx_stb_o  (tx_stb_o),
      .tx_dat_o  (tx_dat_o),
      .tx_done_i (tx_done_i),
      .rx_ireq_o (ireq[irq_defs_pkg::irq_rx]),
      .tx_ireq_o (ireq[irq_defs_pkg::irq_tx]),
      .rx_iack_i (iack[irq_defs_pkg::irq_rx]),
      .tx_iack_i (iack[irq_defs_pkg::irq_tx])
   );

   wbc_vic #(
      .N (irq_defs_pkg::irq_count)
   )
   u_vic
   (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_irq_o (irq_o),
      .wb_dat_o (iak_dat_o),
      .wb_stb_i (iak_stb_i),
      .wb_una_i (iak_una_i),
      .wb_ack_o (iak_ack_o),
      .rsel     (rsel_i),
      .ivec     (ivec),
      .ireq     (ireq),
      .iack     (iack)
   );

endmodule

//--- bench/tb_tasks.svh
// galois lfsr, right shifting, taps 32,22,2,1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step for every bit taken
task automatic draw_bits(input int n, output logic [31:0] r);
   r = '0;
   for (int i = 0; i < n; i++)
   begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
   end
endtask

task automatic report_error(input string msg);
   err_cnt++;
   $display("ERROR at %0t: %s", $time, msg);
endtask

task automatic check_word(input irq_defs_pkg::word_t got, input irq_defs_pkg::word_t exp,
                          input string what);
   assert (got == exp)
   else
      report_error($sformatf("%s gave %h, expected %h", what, got, exp));
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
   assert (got == exp)
   else
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
endtask

// register bus cycle, entered and left on a falling edge
task automatic reg_access(input logic we, input dev_regs_pkg::reg_adr_t adr,
                          input irq_defs_pkg::word_t wdat, output irq_defs_pkg::word_t rdat);
   int n;
   reg_stb_i = 1'b1;
   reg_we_i  = we;
   reg_adr_i = adr;
   reg_dat_i = wdat;
   n = 0;
   do
   begin
      @(negedge wb_clk_i);
      n++;
   end
   while (!reg_ack_o && n < ack_limit);
   if (!reg_ack_o)
   begin
      tmo_cnt++;
      $display("register access at address %0d got no ack", adr);
   end
   rdat      = reg_dat_o;                       // valid during ack
   reg_stb_i = 1'b0;                            // adr and data held into the ack edge
   @(negedge wb_clk_i);                         // side effect done, strobe low a cycle
endtask

task automatic reg_write(input dev_regs_pkg::reg_adr_t adr, input irq_defs_pkg::word_t dat);
   irq_defs_pkg::word_t dummy;
   reg_access(1'b1, adr, dat, dummy);
endtask

task automatic reg_read(input dev_regs_pkg::reg_adr_t adr, output irq_defs_pkg::word_t dat);
   reg_access(1'b0, adr, 16'h0000, dat);
endtask

// interrupt acknowledge cycle, addressed ones wait for irq first
task automatic vector_cycle(input logic una, input irq_defs_pkg::word_t sel,
                            output irq_defs_pkg::word_t dat);
   int n;
   n = 0;
   while (!una && !irq_o && n < irq_limit)
   begin
      @(negedge wb_clk_i);
      n++;
   end
   iak_stb_i = 1'b1;
   iak_una_i = una;
   rsel_i    = sel;
   n = 0;
   do
   begin
      @(negedge wb_clk_i);
      n++;
   end
   while (!iak_ack_o && n < ack_limit);
   if (!iak_ack_o)
   begin
      tmo_cnt++;
      $display("vector cycle got no ack, irq was %b", irq_o);
   end
   dat       = iak_dat_o;
   iak_stb_i = 1'b0;
   iak_una_i = 1'b0;
   @(negedge wb_clk_i);                         // irq already dropped for the served line
endtask

// cycles from the event edge to irq, counted one negedge after that edge
task automatic cycles_to_irq(output int lat);
   int n;
   n = 0;
   while (!irq_o && n < irq_limit)
   begin
      @(negedge wb_clk_i);
      n++;
   end
   lat = irq_o ? n + 1 : irq_limit + 1;
endtask

task automatic hold_irq_low(input int cycles, input string what);
   repeat (cycles)
   begin
      check_bit(irq_o, 1'b0, what);
      @(negedge wb_clk_i);
   end
endtask

task automatic pulse_tick();
   lclk_tick_i = 1'b1;
   @(negedge wb_clk_i);
   lclk_tick_i = 1'b0;
endtask

task automatic send_rx(input dev_regs_pkg::byte_t b);
   rx_stb_i = 1'b1;
   rx_dat_i = b;
   @(negedge wb_clk_i);
   rx_stb_i = 1'b0;
endtask

task automatic pulse_tx_done();
   tx_done_i = 1'b1;
   @(negedge wb_clk_i);
   tx_done_i = 1'b0;
endtask

//--- bench/tb_irq_subsys.sv
`timescale 1ns/1ps

module tb_irq_subsys;

   localparam int clk_period  = 100;            // ns
   localparam int ack_limit   = 8;              // cycles before a handshake is given up
   localparam int irq_limit   = 10;
   localparam int step_count  = 50;             // bus, vector and event steps below
   localparam int step_cycles = 40;
   localparam int watchdog_ns = (step_count * step_cycles + 400) * clk_period;

   logic                   wb_clk_i;
   logic                   wb_rst_i;
   logic                   reg_stb_i;
   logic                   reg_we_i;
   dev_regs_pkg::reg_adr_t reg_adr_i;
   irq_defs_pkg::word_t    reg_dat_i;
   irq_defs_pkg::word_t    reg_dat_o;
   logic                   reg_ack_o;
   logic                   iak_stb_i;
   logic                   iak_una_i;
   irq_defs_pkg::word_t    rsel_i;
   irq_defs_pkg::word_t    iak_dat_o;
   logic                   iak_ack_o;
   logic                   irq_o;
   logic                   lclk_tick_i;
   logic                   rx_stb_i;
   dev_regs_pkg::byte_t    rx_dat_i;
   logic                   tx_stb_o;
   dev_regs_pkg::byte_t    tx_dat_o;
   logic                   tx_done_i;

   int                     err_cnt = 0;         // failed checks
   int                     tmo_cnt = 0;         // handshakes that never came
   int                     tx_seen = 0;         // tx strobes seen
   dev_regs_pkg::byte_t    tx_last;             // byte on the last strobe
   logic [31:0]            lfsr = 32'h5c24;

   `include "tb_tasks.svh"

   irq_subsys UUT
   (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .reg_stb_i   (reg_stb_i),
      .reg_we_i    (reg_we_i),
      .reg_adr_i   (reg_adr_i),
      .reg_dat_i   (reg_dat_i),
      .reg_dat_o   (reg_dat_o),
      .reg_ack_o   (reg_ack_o),
      .iak_stb_i   (iak_stb_i),
      .iak_una_i   (iak_una_i),
      .rsel_i      (rsel_i),
      .iak_dat_o   (iak_dat_o),
      .iak_ack_o   (iak_ack_o),
      .irq_o       (irq_o),
      .lclk_tick_i (lclk_tick_i),
      .rx_stb_i    (rx_stb_i),
      .rx_dat_i    (rx_dat_i),
      .tx_stb_o    (tx_stb_o),
      .tx_dat_o    (tx_dat_o),
      .tx_done_i   (tx_done_i)
   );

   initial
   begin
      wb_clk_i = 1'b0;
      forever #(clk_period / 2) wb_clk_i = ~wb_clk_i;
   end

   always @(negedge wb_clk_i)
   begin
      if (tx_stb_o)
      begin
         tx_seen++;
         tx_last = tx_dat_o;                    // byte handed to the shifter
      end
   end

   // acknowledge line that owns a delivered vector
   function automatic irq_defs_pkg::irq_vec_t line_of_vector(input irq_defs_pkg::word_t v);
      irq_defs_pkg::irq_vec_t m;
      m = '0;
      case (v)
         irq_defs_pkg::vec_lclk: m[irq_defs_pkg::irq_lclk] = 1'b1;
         irq_defs_pkg::vec_rx:   m[irq_defs_pkg::irq_rx]   = 1'b1;
         irq_defs_pkg::vec_tx:   m[irq_defs_pkg::irq_tx]   = 1'b1;
         default:                m = '0;
      endcase
      return m;
   endfunction

   a_reg_ack : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                (reg_stb_i && !reg_ack_o) |=> reg_ack_o)
      else report_error("register ack missing one cycle after strobe");
   a_reg_pulse : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                  reg_ack_o |=> !reg_ack_o)
      else report_error("register ack longer than one cycle");
   a_iak_ack : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                (iak_stb_i && !iak_ack_o && (irq_o || iak_una_i)) |=> iak_ack_o)
      else report_error("vector ack missing one cycle after strobe");
   a_iack_line : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                  (|UUT.iack) |->
                                  (iak_ack_o && (UUT.iack == line_of_vector(iak_dat_o))))
      else report_error("source acknowledge does not match the delivered vector");
   a_una_quiet : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                  (iak_stb_i && iak_una_i && !iak_ack_o) |=> (UUT.iack == '0))
      else report_error("unaddressed vector cycle acknowledged a source");
   a_tx_pulse : assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
                                 tx_stb_o |=> !tx_stb_o)
      else report_error("tx strobe longer than one cycle");

   initial
   begin
      #(watchdog_ns);
      $display("watchdog expired after %0d ns, the scenarios did not complete", watchdog_ns);
      $display("check errors %0d, handshake timeouts %0d", err_cnt, tmo_cnt);
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      irq_defs_pkg::word_t dat;
      irq_defs_pkg::word_t rsel_w;
      dev_regs_pkg::byte_t b;
      logic [31:0]         rnd;
      int                  lat;
      int                  seen0;
      wb_rst_i    = 1'b1;                       // reset from time zero
      reg_stb_i   = 1'b0;
      reg_we_i    = 1'b0;
      reg_adr_i   = '0;
      reg_dat_i   = '0;
      iak_stb_i   = 1'b0;
      iak_una_i   = 1'b0;
      rsel_i      = '0;
      lclk_tick_i = 1'b0;
      rx_stb_i    = 1'b0;
      rx_dat_i    = '0;
      tx_done_i   = 1'b0;
      repeat (5) @(negedge wb_clk_i);
      wb_rst_i = 1'b0;

      // reset state
      check_bit(irq_o, 1'b0, "irq after reset");
      check_bit(iak_ack_o, 1'b0, "vector ack after reset");
      check_bit(reg_ack_o, 1'b0, "register ack after reset");
      check_bit(tx_stb_o, 1'b0, "tx strobe after reset");
      reg_read(dev_regs_pkg::adr_xcsr, dat);
      check_word(dat, 16'h0080, "xcsr after reset");   // ready only
      reg_read(dev_regs_pkg::adr_rcsr, dat);
      check_word(dat, 16'h0000, "rcsr after reset");
      reg_read(dev_regs_pkg::adr_lks, dat);
      check_word(dat, 16'h0000, "lks after reset");

      // single source from the line clock
      reg_write(dev_regs_pkg::adr_lks, 16'h0040);
      draw_bits(3, rnd);
      repeat (rnd[2:0]) @(negedge wb_clk_i);   // random tick gap
      pulse_tick();
      cycles_to_irq(lat);
      assert (lat <= 3) else report_error($sformatf("tick to irq took %0d cycles", lat));
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_lclk, "line clock vector");
      hold_irq_low(8, "irq after line clock served");
      pulse_tick();                             // next tick requests again
      cycles_to_irq(lat);
      assert (lat <= 3) else report_error($sformatf("second tick took %0d cycles", lat));
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_lclk, "line clock vector again");

      // priority with all three pending
      reg_write(dev_regs_pkg::adr_rcsr, 16'h0040);
      reg_write(dev_regs_pkg::adr_lks, 16'h0040);
      draw_bits(8, rnd);
      send_rx(rnd[7:0]);
      pulse_tick();
      reg_write(dev_regs_pkg::adr_xcsr, 16'h0040); // ready already set so it pends
      repeat (3) @(negedge wb_clk_i);
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_lclk, "first priority vector");
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_rx, "second priority vector");
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_tx, "third priority vector");
      hold_irq_low(5, "irq after all sources served");

      // unaddressed read leaves the request alone
      pulse_tick();
      cycles_to_irq(lat);
      draw_bits(16, rnd);
      rsel_w = rnd[15:0];
      vector_cycle(1'b1, rsel_w, dat);
      check_word(dat, rsel_w, "unaddressed read");
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_lclk, "vector after unaddressed read");
      hold_irq_low(4, "irq after unaddressed test");

      // console data path with interrupts off
      reg_write(dev_regs_pkg::adr_rcsr, 16'h0000);
      reg_write(dev_regs_pkg::adr_xcsr, 16'h0000);
      reg_write(dev_regs_pkg::adr_lks, 16'h0000);  // also clears the monitor flag
      draw_bits(8, rnd);
      b = rnd[7:0];
      send_rx(b);
      reg_read(dev_regs_pkg::adr_rcsr, dat);
      check_word(dat, 16'h0080, "rcsr with a byte waiting");
      reg_read(dev_regs_pkg::adr_rbuf, dat);
      check_word(dat, irq_defs_pkg::word_t'(b), "rbuf");
      reg_read(dev_regs_pkg::adr_rcsr, dat);
      check_word(dat, 16'h0000, "rcsr after rbuf read");
      draw_bits(8, rnd);
      b     = rnd[7:0];
      seen0 = tx_seen;
      reg_write(dev_regs_pkg::adr_xbuf, irq_defs_pkg::word_t'(b));
      reg_read(dev_regs_pkg::adr_xcsr, dat);
      check_word(dat, 16'h0000, "xcsr while sending");
      assert (tx_seen == seen0 + 1)
      else
         report_error($sformatf("%0d tx strobes for one xbuf write", tx_seen - seen0));
      check_word(irq_defs_pkg::word_t'(tx_last), irq_defs_pkg::word_t'(b), "tx byte");
      pulse_tx_done();
      reg_read(dev_regs_pkg::adr_xcsr, dat);
      check_word(dat, 16'h0080, "xcsr after tx done");
      check_bit(irq_o, 1'b0, "irq during console path");

      // enable gating
      pulse_tick();
      draw_bits(8, rnd);
      send_rx(rnd[7:0]);
      hold_irq_low(6, "irq with enables clear");
      reg_read(dev_regs_pkg::adr_lks, dat);
      check_word(dat, 16'h0080, "lks flag with ie clear");
      reg_read(dev_regs_pkg::adr_rcsr, dat);
      check_word(dat, 16'h0080, "rcsr done with ie clear");
      reg_write(dev_regs_pkg::adr_lks, 16'h00c0);  // keep flag and raise ie
      cycles_to_irq(lat);
      assert (lat <= 3) else report_error($sformatf("lks ie to irq took %0d cycles", lat));
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_lclk, "vector after lks ie");
      hold_irq_low(4, "irq after lks served");
      reg_write(dev_regs_pkg::adr_rcsr, 16'h0040);
      cycles_to_irq(lat);
      assert (lat <= 3) else report_error($sformatf("rcsr ie to irq took %0d cycles", lat));
      vector_cycle(1'b0, 16'h0000, dat);
      check_word(dat, irq_defs_pkg::vec_rx, "vector after rcsr ie");
      hold_irq_low(4, "irq at the end");

      $display("check errors %0d, handshake timeouts %0d", err_cnt, tmo_cnt);
      if (err_cnt == 0 && tmo_cnt == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

//--- all.f
+incdir+bench
source/irq_defs_pkg.sv
source/dev_regs_pkg.sv
source/wbc_vic.sv
source/line_clock.sv
source/console_port.sv
source/irq_subsys.sv
bench/tb_irq_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the interrupt subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
   echo "verilator not found in PATH"
   exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      -f all.f --top-module tb_irq_subsys \
      --Mdir obj_dir -o sim_irq_subsys; then
   echo "verilator build failed"
   exit 1
fi

if ! sim_out=$(./obj_dir/sim_irq_subsys 2>&1); then
   echo "$sim_out"
   echo "simulation exited with a failing status"
   exit 1
fi

echo "$sim_out"

if grep -q "Finished with no errors" <<< "$sim_out"; then
   echo "run passed"
   exit 0
fi

echo "run failed"
exit 1
